// File: rtl/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Architectural register file
`define REG_NUM 32
`define REG_IDX_W 5
`define DATA_W 32

// Instruction fields carried through dispatch
`define ADDR_W 32
`define OP_W 7
`define IMM_W 32

// Reorder buffer geometry
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// Nick 0 means "not renamed", so one extra bit over the entry index
`define NICK_W 4

`endif

// File: rtl/renamePkg.sv
`include "core_params.svh"

package renamePkg;

    typedef logic [`REG_IDX_W-1:0] regName_t;

    typedef logic [`NICK_W-1:0] nick_t;

    // One decoded instruction whose valid is a single cycle strobe
    typedef struct packed {
        logic               valid;
        regName_t           rs1;
        regName_t           rs2;
        regName_t           rd;
        logic [`OP_W-1:0]   op;
        logic [`ADDR_W-1:0] pc;
        logic [`IMM_W-1:0]  imm;
        logic               pd;     // Predicted taken
    } decodedInstr_t;

    // A source operand is either a value (nick 0) or a pending nick
    typedef struct packed {
        nick_t              nick;
        logic [`DATA_W-1:0] data;
    } operand_t;

    typedef struct packed {
        logic               valid;
        operand_t           src1;
        operand_t           src2;
        nick_t              rdNick;  // Nick allocated for rd
        regName_t           rd;
        logic [`OP_W-1:0]   op;
        logic [`ADDR_W-1:0] pc;
        logic [`IMM_W-1:0]  imm;
        logic               pd;
    } dispatchPacket_t;

    // Result coming back from the execution unit
    typedef struct packed {
        logic               valid;
        nick_t              nick;
        logic [`DATA_W-1:0] data;
    } writeback_t;

    typedef struct packed {
        logic               valid;
        regName_t           rd;
        nick_t              nick;
        logic [`DATA_W-1:0] data;
    } commit_t;

endpackage

// File: rtl/regFile.sv
`timescale 1ns/100ps
`include "core_params.svh"

module regFile import renamePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    // Operand read ports
    input  regName_t           rs1,
    input  regName_t           rs2,
    output logic [`DATA_W-1:0] rs1Data,
    output logic [`DATA_W-1:0] rs2Data,
    output nick_t              rs1Nick,
    output nick_t              rs2Nick,

    // Rename of the destination at dispatch
    input  logic               renEn,
    input  regName_t           renReg,
    input  nick_t              renNick,

    // Retirement from the reorder buffer
    input  commit_t            commit
);

    logic [`DATA_W-1:0] regData [`REG_NUM];
    nick_t              regNick [`REG_NUM];

    logic commitWrite;
    logic commitMatch;
    logic renWrite;

    assign commitWrite = commit.valid && (commit.rd != '0);

    // A younger rename leaves the tag in place, so only the owner clears it
    assign commitMatch = commitWrite && (regNick[commit.rd] == commit.nick);

    assign renWrite = renEn && (renReg != '0);

    // x0 is hardwired, whatever the arrays hold
    always_comb begin
        if (rs1 == '0) begin
            rs1Data = '0;
            rs1Nick = '0;
        end else begin
            rs1Data = regData[rs1];
            rs1Nick = regNick[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2Data = '0;
            rs2Nick = '0;
        end else begin
            rs2Data = regData[rs2];
            rs2Nick = regNick[rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regData[i] <= '0;
            end
        end else if (commitWrite) begin
            regData[commit.rd] <= commit.data;  // Retiring data lands even on a flush
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regNick[i] <= '0;
            end
        end else begin
            if (commitMatch) begin
                regNick[commit.rd] <= '0;
            end
            // Rename is written last so it wins over a clear of the same register
            if (renWrite) begin
                regNick[renReg] <= renNick;
            end
        end
    end

endmodule

// File: rtl/reorderBuffer.sv
`timescale 1ns/100ps
`include "core_params.svh"

module reorderBuffer import renamePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    // Allocation from dispatch
    input  logic               allocEn,
    input  regName_t           allocRd,
    output nick_t              allocNick,
    output logic               full,

    // Result from the execution unit
    input  writeback_t         wb,

    // Operand lookups
    input  nick_t              look1,
    input  nick_t              look2,
    output logic               look1Ready,
    output logic               look2Ready,
    output logic [`DATA_W-1:0] look1Data,
    output logic [`DATA_W-1:0] look2Data,

    output commit_t            commit
);

    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] done;
    regName_t              entryRd   [`ROB_DEPTH];
    logic [`DATA_W-1:0]    entryData [`ROB_DEPTH];

    logic [`ROB_IDX_W-1:0] head;
    logic [`ROB_IDX_W-1:0] tail;
    logic [`ROB_IDX_W-1:0] headNext;
    logic [`ROB_IDX_W:0]   count;

    logic                  allocGo;
    logic                  retire;
    logic                  wbHit;
    logic [`ROB_IDX_W-1:0] wbIdx;

    // Nick n names entry n-1
    function automatic logic [`ROB_IDX_W-1:0] nickToIdx(nick_t n);
        return n[`ROB_IDX_W-1:0] - `ROB_IDX_W'(1);
    endfunction

    function automatic nick_t idxToNick(logic [`ROB_IDX_W-1:0] idx);
        return nick_t'(idx) + nick_t'(1);
    endfunction

    function automatic logic nickLive(nick_t n);
        return (n != '0) && (n <= nick_t'(`ROB_DEPTH));
    endfunction

    assign full      = (count == (`ROB_IDX_W+1)'(`ROB_DEPTH));
    assign allocNick = idxToNick(tail);
    assign allocGo   = allocEn && !full;

    // The head leaves at the edge after it is marked done
    assign retire   = busy[head] && done[head];
    assign headNext = retire ? head + `ROB_IDX_W'(1) : head;

    always_comb begin
        commit.valid = retire;
        commit.rd    = entryRd[head];
        commit.nick  = idxToNick(head);
        commit.data  = entryData[head];
    end

    // Stale or repeated writebacks fall out here
    assign wbIdx = nickToIdx(wb.nick);
    assign wbHit = wb.valid && nickLive(wb.nick) && busy[wbIdx] && !done[wbIdx];

    // The retiring head is still done here, so it is covered by the lookup too
    always_comb begin
        look1Ready = nickLive(look1) && busy[nickToIdx(look1)] && done[nickToIdx(look1)];
        look2Ready = nickLive(look2) && busy[nickToIdx(look2)] && done[nickToIdx(look2)];
        look1Data  = entryData[nickToIdx(look1)];
        look2Data  = entryData[nickToIdx(look2)];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            busy  <= '0;
            done  <= '0;
        end else if (flush) begin
            // Allocation restarts where the head stands after this edge
            head  <= headNext;
            tail  <= headNext;
            count <= '0;
            busy  <= '0;
            done  <= '0;
        end else begin
            head  <= headNext;
            count <= count + (`ROB_IDX_W+1)'(allocGo) - (`ROB_IDX_W+1)'(retire);
            if (retire) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
            end
            if (wbHit) begin
                done[wbIdx] <= 1'b1;
            end
            if (allocGo) begin
                tail       <= tail + `ROB_IDX_W'(1);
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocGo) begin
            entryRd[tail] <= allocRd;
        end
        if (wbHit) begin
            entryData[wbIdx] <= wb.data;
        end
    end

endmodule

// File: rtl/dispatchStage.sv
`timescale 1ns/100ps
`include "core_params.svh"

module dispatchStage import renamePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  decodedInstr_t      instr,
    input  logic               full,

    // Register file reads
    output regName_t           rs1,
    output regName_t           rs2,
    input  logic [`DATA_W-1:0] rs1Data,
    input  logic [`DATA_W-1:0] rs2Data,
    input  nick_t              rs1Nick,
    input  nick_t              rs2Nick,

    // Reorder buffer lookups and allocation
    output nick_t              look1,
    output nick_t              look2,
    input  logic               look1Ready,
    input  logic               look2Ready,
    input  logic [`DATA_W-1:0] look1Data,
    input  logic [`DATA_W-1:0] look2Data,
    output logic               allocEn,
    output regName_t           allocRd,
    input  nick_t              allocNick,
    input  commit_t            commit,

    output dispatchPacket_t    disp
);

    logic     accept;
    operand_t src1;
    operand_t src2;

    function automatic operand_t resolve(regName_t r, logic [`DATA_W-1:0] regData,
                                         nick_t regNick, logic robReady,
                                         logic [`DATA_W-1:0] robData, commit_t c);
        operand_t o;
        o.nick = '0;
        o.data = '0;
        if (r == '0) begin
            o.data = '0;
        end else if (regNick == '0) begin
            o.data = regData;
        end else if (c.valid && (c.nick == regNick)) begin
            o.data = c.data;  // Register is written at this same edge
        end else if (robReady) begin
            o.data = robData;
        end else begin
            o.nick = regNick;
        end
        return o;
    endfunction

    assign rs1   = instr.rs1;
    assign rs2   = instr.rs2;
    assign look1 = rs1Nick;
    assign look2 = rs2Nick;

    // Sources are resolved against state before this instruction's own rename
    assign src1 = resolve(instr.rs1, rs1Data, rs1Nick, look1Ready, look1Data, commit);
    assign src2 = resolve(instr.rs2, rs2Data, rs2Nick, look2Ready, look2Data, commit);

    assign accept  = instr.valid && !full && !flush;
    assign allocEn = accept;
    assign allocRd = instr.rd;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            disp.valid <= 1'b0;
        end else begin
            disp.valid <= accept;
            if (accept) begin
                disp.src1   <= src1;
                disp.src2   <= src2;
                disp.rdNick <= allocNick;
                disp.rd     <= instr.rd;
                disp.op     <= instr.op;
                disp.pc     <= instr.pc;
                disp.imm    <= instr.imm;
                disp.pd     <= instr.pd;
            end
        end
    end

endmodule

// File: rtl/renameCore.sv
`timescale 1ns/100ps
`include "core_params.svh"

module renameCore import renamePkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            flush,
    input  decodedInstr_t   instr,
    input  writeback_t      wb,
    output dispatchPacket_t disp,
    output commit_t         commit,
    output logic            full
);

    regName_t           rs1;
    regName_t           rs2;
    logic [`DATA_W-1:0] rs1Data;
    logic [`DATA_W-1:0] rs2Data;
    nick_t              rs1Nick;
    nick_t              rs2Nick;

    nick_t              look1;
    nick_t              look2;
    logic               look1Ready;
    logic               look2Ready;
    logic [`DATA_W-1:0] look1Data;
    logic [`DATA_W-1:0] look2Data;

    logic               allocEn;
    regName_t           allocRd;
    nick_t              allocNick;

    regFile regs (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .rs1Nick (rs1Nick),
        .rs2Nick (rs2Nick),
        .renEn   (allocEn),   // The rename uses the nick handed out this cycle
        .renReg  (allocRd),
        .renNick (allocNick),
        .commit  (commit)
    );

    reorderBuffer rob (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .allocEn    (allocEn),
        .allocRd    (allocRd),
        .allocNick  (allocNick),
        .full       (full),
        .wb         (wb),
        .look1      (look1),
        .look2      (look2),
        .look1Ready (look1Ready),
        .look2Ready (look2Ready),
        .look1Data  (look1Data),
        .look2Data  (look2Data),
        .commit     (commit)
    );

    dispatchStage dispatch (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .instr      (instr),
        .full       (full),
        .rs1        (rs1),
        .rs2        (rs2),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .rs1Nick    (rs1Nick),
        .rs2Nick    (rs2Nick),
        .look1      (look1),
        .look2      (look2),
        .look1Ready (look1Ready),
        .look2Ready (look2Ready),
        .look1Data  (look1Data),
        .look2Data  (look2Data),
        .allocEn    (allocEn),
        .allocRd    (allocRd),
        .allocNick  (allocNick),
        .commit     (commit),
        .disp       (disp)
    );

endmodule

// File: test/renameModel.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Reference state of the core, advanced once per rising edge by modelStep
logic [`DATA_W-1:0] archData [`REG_NUM];
nick_t              archNick [`REG_NUM];
logic               robBusy  [`ROB_DEPTH];
logic               robDone  [`ROB_DEPTH];
regName_t           robRd    [`ROB_DEPTH];
logic [`DATA_W-1:0] robData  [`ROB_DEPTH];
int                 robHead;
int                 robTail;
int                 robCount;
dispatchPacket_t    expDisp;    // Packet that disp must show after the coming edge

task automatic modelReset();
    for (int i = 0; i < `REG_NUM; i++) begin
        archData[i] = '0;
        archNick[i] = '0;
    end
    for (int i = 0; i < `ROB_DEPTH; i++) begin
        robBusy[i] = 1'b0;
        robDone[i] = 1'b0;
        robRd[i]   = '0;
        robData[i] = '0;
    end
    robHead  = 0;
    robTail  = 0;
    robCount = 0;
    expDisp  = '0;
endtask

function automatic logic modelFull();
    return robCount == `ROB_DEPTH;
endfunction

// The head retires at the coming edge once its result is in
function automatic commit_t modelCommit();
    commit_t c;
    c.valid = robBusy[robHead] && robDone[robHead];
    c.rd    = robRd[robHead];
    c.nick  = nick_t'(robHead + 1);
    c.data  = robData[robHead];
    return c;
endfunction

function automatic operand_t modelOperand(regName_t r);
    operand_t o;
    int       idx;
    o   = '0;
    idx = int'(archNick[r]) - 1;
    if (r == '0) begin
        o.data = '0;
    end else if (archNick[r] == '0) begin
        o.data = archData[r];
    end else if (robDone[idx]) begin
        o.data = robData[idx];  // Complete, which includes a head retiring now
    end else begin
        o.nick = archNick[r];
    end
    return o;
endfunction

task automatic modelStep(input decodedInstr_t in, input writeback_t w, input logic fl);
    commit_t c;
    logic    accept;
    int      wi;
    c       = modelCommit();
    accept  = in.valid && !modelFull() && !fl;
    expDisp = '0;
    if (accept) begin
        expDisp.valid  = 1'b1;
        expDisp.src1   = modelOperand(in.rs1);
        expDisp.src2   = modelOperand(in.rs2);
        expDisp.rdNick = nick_t'(robTail + 1);
        expDisp.rd     = in.rd;
        expDisp.op     = in.op;
        expDisp.pc     = in.pc;
        expDisp.imm    = in.imm;
        expDisp.pd     = in.pd;
    end
    if (c.valid && c.rd != '0) begin
        archData[c.rd] = c.data;
        if (archNick[c.rd] == c.nick) begin
            archNick[c.rd] = '0;
        end
    end
    if (accept && in.rd != '0) begin
        archNick[in.rd] = expDisp.rdNick;   // A new rename beats the clear above
    end
    if (c.valid) begin
        robBusy[robHead] = 1'b0;
        robDone[robHead] = 1'b0;
        robHead  = (robHead + 1) % `ROB_DEPTH;
        robCount = robCount - 1;
    end
    if (fl) begin
        for (int i = 0; i < `REG_NUM; i++) begin
            archNick[i] = '0;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            robBusy[i] = 1'b0;
            robDone[i] = 1'b0;
        end
        robTail  = robHead;
        robCount = 0;
    end else begin
        wi = int'(w.nick) - 1;
        if (w.valid && wi >= 0 && wi < `ROB_DEPTH) begin
            if (robBusy[wi] && !robDone[wi]) begin
                robDone[wi] = 1'b1;
                robData[wi] = w.data;
            end
        end
        if (accept) begin
            robBusy[robTail] = 1'b1;
            robDone[robTail] = 1'b0;
            robRd[robTail]   = in.rd;
            robTail  = (robTail + 1) % `ROB_DEPTH;
            robCount = robCount + 1;
        end
    end
endtask

`endif

// File: test/tbRenameCore.sv
`timescale 1ns/100ps
`include "core_params.svh"

module tbRenameCore import renamePkg::*; ();

    logic            clk = 1'b0;
    logic            rst;
    logic            flush;
    decodedInstr_t   instr;
    writeback_t      wb;
    dispatchPacket_t disp;
    commit_t         commit;
    logic            full;

    logic [31:0] lfsr = 32'h2972;
    nick_t       outstanding[$];    // Nicks handed out and not yet written back
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failedTests = 0;
    int          testStartErrors = 0;
    writeback_t  w;
    int          guard;

    `include "renameModel.svh"

    renameCore uut (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .instr  (instr),
        .wb     (wb),
        .disp   (disp),
        .commit (commit),
        .full   (full)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic decodedInstr_t randInstr(input logic v);
        decodedInstr_t d;
        d.valid = v;
        d.rs1   = regName_t'(randBits(3));  // Only x0 to x7 so that dependences are common
        d.rs2   = regName_t'(randBits(3));
        d.rd    = regName_t'(randBits(3));
        d.op    = `OP_W'(randBits(`OP_W));
        d.pc    = randBits(`ADDR_W);
        d.imm   = randBits(`IMM_W);
        d.pd    = 1'(randBits(1));
        return d;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] got,
                                input logic [63:0] want);
        checks++;
        if (got !== want) begin
            $display("mismatch %s at %0t: expected %h, got %h", name, $time, want, got);
            errors++;
        end
    endtask

    task automatic checkOutputs();
        commit_t c;
        c = modelCommit();
        compareValue("full", full, modelFull());
        compareValue("commit.valid", commit.valid, c.valid);
        if (c.valid) begin
            compareValue("commit.rd", commit.rd, c.rd);
            compareValue("commit.nick", commit.nick, c.nick);
            compareValue("commit.data", commit.data, c.data);
        end
        compareValue("disp.valid", disp.valid, expDisp.valid);
        if (expDisp.valid) begin
            compareValue("disp.src1", disp.src1, expDisp.src1);
            compareValue("disp.src2", disp.src2, expDisp.src2);
            compareValue("disp.rdNick", disp.rdNick, expDisp.rdNick);
            compareValue("disp.rd", disp.rd, expDisp.rd);
            compareValue("disp.op", disp.op, expDisp.op);
            compareValue("disp.pc", disp.pc, expDisp.pc);
            compareValue("disp.imm", disp.imm, expDisp.imm);
            compareValue("disp.pd", disp.pd, expDisp.pd);
        end
    endtask

    // Plays the execution unit; with nothing outstanding it sometimes sends a stale nick
    task automatic pickWriteback(output writeback_t res, input logic on);
        int k;
        res = '0;
        if (on && outstanding.size() > 0) begin
            k         = int'(randBits(8)) % outstanding.size();
            res.valid = 1'b1;
            res.nick  = outstanding[k];
            res.data  = randBits(`DATA_W);
            outstanding.delete(k);
        end else if (on && randBits(3) == 0) begin
            res.valid = 1'b1;
            res.nick  = nick_t'(randBits(`NICK_W));
            res.data  = randBits(`DATA_W);
        end
    endtask

    // Called at a falling edge to check, drive, advance the model and wait for the next one
    task runCycle(input decodedInstr_t d, input writeback_t r, input logic f);
        checkOutputs();
        instr = d;
        wb    = r;
        flush = f;
        if (d.valid && !modelFull() && !f) begin
            outstanding.push_back(nick_t'(robTail + 1));
        end
        modelStep(d, r, f);
        if (f) begin
            outstanding.delete();
        end
        @(negedge clk);
    endtask

    // Reads every register as a source, with rd x0 so nothing gets renamed
    task readAllRegs();
        decodedInstr_t d;
        writeback_t    r;
        int            regIdx;
        int            limit;
        regIdx = 0;
        limit  = 0;
        while (regIdx < `REG_NUM && limit < 200) begin
            d     = randInstr(!modelFull());
            d.rs1 = regName_t'(regIdx);
            d.rs2 = regName_t'(`REG_NUM - 1 - regIdx);
            d.rd  = '0;
            if (d.valid) begin
                regIdx++;
            end
            pickWriteback(r, 1'b1);
            runCycle(d, r, 1'b0);
            limit++;
        end
        if (regIdx < `REG_NUM) begin
            $display("register sweep timed out after %0d of %0d reads", regIdx, `REG_NUM);
            errors++;
        end
    endtask

    task automatic finishTest(input string name);
        tests++;
        if (errors != testStartErrors) begin
            failedTests++;
        end
        $display("%s finished: %0d errors", name, errors - testStartErrors);
        testStartErrors = errors;
    endtask

    initial begin
        rst   = 1'b1;
        flush = 1'b0;
        instr = '0;
        wb    = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        modelReset();

        for (int i = 0; i < 400; i++) begin
            pickWriteback(w, randBits(1) == 1);
            runCycle(randInstr(randBits(1) == 1 && !modelFull()), w, randBits(6) == 0);
        end
        finishTest("random traffic");

        // No results come back, so the buffer must fill up
        guard = 0;
        while (!modelFull() && guard < 40) begin
            runCycle(randInstr(1'b1), '0, 1'b0);
            guard++;
        end
        if (!modelFull()) begin
            $display("the reorder buffer never filled");
            errors++;
        end
        for (int i = 0; i < 3; i++) begin
            runCycle(randInstr(1'b1), '0, 1'b0);
        end
        finishTest("full");

        for (int i = 0; i < 3; i++) begin
            pickWriteback(w, 1'b1);
            runCycle(randInstr(1'b0), w, 1'b0);
        end
        runCycle(randInstr(1'b1), '0, 1'b1);
        readAllRegs();
        finishTest("flush");

        for (int i = 0; i < 200; i++) begin
            pickWriteback(w, randBits(2) != 0);
            runCycle(randInstr(randBits(1) == 1 && !modelFull()), w, 1'b0);
        end
        guard = 0;
        while (robCount != 0 && guard < 200) begin
            pickWriteback(w, 1'b1);
            runCycle(randInstr(1'b0), w, 1'b0);
            guard++;
        end
        if (robCount != 0) begin
            $display("the reorder buffer did not drain in time");
            errors++;
        end
        readAllRegs();
        checkOutputs();
        finishTest("commit and drain");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failedTests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+rtl
+incdir+test
rtl/renamePkg.sv
rtl/regFile.sv
rtl/reorderBuffer.sv
rtl/dispatchStage.sv
rtl/renameCore.sv
test/tbRenameCore.sv

// File: run.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and scans the log for a failure
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tbRenameCore -f files.f -o simRenameCore \
    && ./obj_dir/simRenameCore | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -q "Test FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
exit 0
